// File: design/test_mem_config.svh
/*
 * Build-time constants of the multi-ported test memory
 * Port count, address and data widths, length field and physical size
 */

`ifndef TEST_MEM_CONFIG_SVH
`define TEST_MEM_CONFIG_SVH

// Number of independent request/response ports
`define TM_NUM_PORTS 4

// Request byte address width
// Bits above the physical size are ignored
`define TM_ADDR_W 16

// Data width of requests and responses, a whole number of bytes
`define TM_DATA_W 32

// Physical storage in bytes, a power of two
`define TM_MEM_BYTES 256

// Length field width, zero encodes a full word
`define TM_LEN_W 2

`endif

// File: design/mem_msg_pkg.sv
/*
 * Memory message definitions
 * Opcode enum, request struct and response struct
 */

`default_nettype none

`include "test_mem_config.svh"

package mem_msg_pkg;

  // --------------------
  // Opcode
  // --------------------

  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

  // --------------------
  // Request message
  // --------------------

  // Byte address of any alignment
  // Length counts bytes, zero means a full word
  typedef struct packed {
    mem_op_e               op;
    logic [`TM_ADDR_W-1:0] addr;
    logic [`TM_LEN_W-1:0]  len;
    logic [`TM_DATA_W-1:0] data;
  } mem_req_t;

  // --------------------
  // Response message
  // --------------------

  // Op and length echo the request
  // Data is the addressed word shifted down by the byte offset
  typedef struct packed {
    mem_op_e               op;
    logic [`TM_LEN_W-1:0]  len;
    logic [`TM_DATA_W-1:0] data;
  } mem_resp_t;

endpackage

`default_nettype wire

// File: design/mem_geom_pkg.sv
/*
 * Physical geometry of the storage array
 * Derived sizes, block address, byte offset, byte count, write command
 */

`default_nettype none

`include "test_mem_config.svh"

package mem_geom_pkg;

  // --------------------
  // Derived sizes
  // --------------------

  localparam int word_bytes  = `TM_DATA_W / 8;
  localparam int num_words   = `TM_MEM_BYTES / word_bytes;
  localparam int phys_addr_w = $clog2(`TM_MEM_BYTES);
  localparam int offset_w    = $clog2(word_bytes);
  localparam int block_w     = $clog2(num_words);
  // One extra bit so a full word count fits
  localparam int count_w     = $clog2(word_bytes) + 1;

  // --------------------
  // Address pieces
  // --------------------

  // Word index into the array
  typedef logic [block_w-1:0]  block_addr_t;

  // Byte lane inside a word
  typedef logic [offset_w-1:0] byte_offset_t;

  // Effective length, 1 up to word_bytes
  typedef logic [count_w-1:0]  byte_count_t;

  // --------------------
  // Write command
  // --------------------

  // Data byte 0 lands at lane offset, bytes past the word end are lost
  typedef struct packed {
    logic                  en;
    block_addr_t           block_addr;
    byte_offset_t          offset;
    byte_count_t           count;
    logic [`TM_DATA_W-1:0] data;
  } mem_write_t;

endpackage

`default_nettype wire

// File: design/mem_port_stage.sv
/*
 * One port of the test memory
 * Request buffer with strict stall, address split, length fix-up,
 * read alignment and write command generation
 */

`timescale 1ns/100ps
`default_nettype none

`include "test_mem_config.svh"

module mem_port_stage (
  input  logic                       clk,
  input  logic                       reset,

  // Request side
  input  logic                       memreq_val_i,
  input  mem_msg_pkg::mem_req_t      memreq_msg_i,
  output logic                       memreq_rdy_o,

  // Response side
  output logic                       memresp_val_o,
  output mem_msg_pkg::mem_resp_t     memresp_msg_o,
  input  logic                       memresp_rdy_i,

  // Array read port
  output mem_geom_pkg::block_addr_t  rd_addr_o,
  input  logic [`TM_DATA_W-1:0]      rd_word_i,

  // Array write port
  output mem_geom_pkg::mem_write_t   wr_cmd_o
);

  // --------------------
  // Request buffer
  // --------------------

  logic                        req_val_q;
  mem_msg_pkg::mem_req_t       req_q;

  // Valid bit clears on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      req_val_q <= 1'b0;
    end else if (memresp_rdy_i) begin
      req_val_q <= memreq_val_i;
    end
  end

  // Payload loads on every ready cycle even without valid
  always_ff @(posedge clk) begin
    if (memresp_rdy_i) begin
      req_q <= memreq_msg_i;
    end
  end

  // Strict pipeline
  // The buffer frees up exactly when its response is taken
  assign memreq_rdy_o = memresp_rdy_i;

  // --------------------
  // Address decode
  // --------------------

  logic [mem_geom_pkg::phys_addr_w-1:0] phys_addr;
  mem_geom_pkg::block_addr_t            blk_addr;
  mem_geom_pkg::byte_offset_t           blk_off;

  // Upper request address bits fall outside the array and are dropped
  assign phys_addr = req_q.addr[mem_geom_pkg::phys_addr_w-1:0];

  // Word index above the lane bits
  assign blk_addr  = phys_addr[mem_geom_pkg::phys_addr_w-1:mem_geom_pkg::offset_w];
  assign blk_off   = phys_addr[mem_geom_pkg::offset_w-1:0];

  assign rd_addr_o = blk_addr;

  // --------------------
  // Length fix-up
  // --------------------

  mem_geom_pkg::byte_count_t byte_cnt;

  // Zero length stands for a whole word
  always_comb begin
    if (req_q.len == '0) begin
      byte_cnt = mem_geom_pkg::byte_count_t'(mem_geom_pkg::word_bytes);
    end else begin
      byte_cnt = mem_geom_pkg::byte_count_t'(req_q.len);
    end
  end

  // --------------------
  // Read alignment
  // --------------------

  logic [`TM_DATA_W-1:0] rd_data;

  // Addressed byte moves to lane 0 with zeros filled in at the top
  assign rd_data = rd_word_i >> {blk_off, 3'b000};

  // Response echoes op and raw length
  assign memresp_val_o = req_val_q;
  assign memresp_msg_o = '{
    op:   req_q.op,
    len:  req_q.len,
    data: rd_data
  };

  // --------------------
  // Write command
  // --------------------

  // Held during a stall so the same bytes are rewritten
  // Rewriting identical data leaves the array unchanged
  assign wr_cmd_o = '{
    en:         req_val_q && (req_q.op == mem_msg_pkg::op_write),
    block_addr: blk_addr,
    offset:     blk_off,
    count:      byte_cnt,
    data:       req_q.data
  };

endmodule

`default_nettype wire

// File: design/mem_array.sv
/*
 * Word-organized storage shared by all ports
 * Combinational read per port, byte-merging write per port
 * Same-edge writes to one byte resolve to the highest port
 */

`timescale 1ns/100ps
`default_nettype none

`include "test_mem_config.svh"

module mem_array (
  input  logic                      clk,

  // One read address and word per port
  input  mem_geom_pkg::block_addr_t rd_addr_i [`TM_NUM_PORTS],
  output logic [`TM_DATA_W-1:0]     rd_word_o [`TM_NUM_PORTS],

  // One write command per port
  input  mem_geom_pkg::mem_write_t  wr_cmd_i  [`TM_NUM_PORTS]
);

  localparam int wb = mem_geom_pkg::word_bytes;

  // --------------------
  // Storage
  // --------------------

  logic [`TM_DATA_W-1:0] mem_q [mem_geom_pkg::num_words];

  // --------------------
  // Read ports
  // --------------------

  // Reads see the contents before this edge's writes
  always_comb begin
    for (int p = 0; p < `TM_NUM_PORTS; p++) begin
      rd_word_o[p] = mem_q[rd_addr_i[p]];
    end
  end

  // --------------------
  // Write lane decode
  // --------------------

  logic [wb-1:0]         wr_be   [`TM_NUM_PORTS];
  logic [`TM_DATA_W-1:0] wr_data [`TM_NUM_PORTS];

  always_comb begin
    for (int p = 0; p < `TM_NUM_PORTS; p++) begin
      // Low count bits set, then moved up to the starting lane
      // Enables shifted past the top lane drop out
      if (wr_cmd_i[p].en) begin
        wr_be[p] = ({wb{1'b1}} >> (wb - int'(wr_cmd_i[p].count)))
                   << wr_cmd_i[p].offset;
      end else begin
        wr_be[p] = '0;
      end
      // Data byte 0 lines up with the starting lane
      wr_data[p] = wr_cmd_i[p].data << {wr_cmd_i[p].offset, 3'b000};
    end
  end

  // --------------------
  // Write merge
  // --------------------

  // Ports in ascending order
  // The last assignment to a byte wins, so port N beats port N-1
  always_ff @(posedge clk) begin
    for (int p = 0; p < `TM_NUM_PORTS; p++) begin
      for (int b = 0; b < wb; b++) begin
        if (wr_be[p][b]) begin
          mem_q[wr_cmd_i[p].block_addr][b*8 +: 8] <= wr_data[p][b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/test_mem_multiport.sv
/*
 * Multi-ported behavioral test memory, top level
 * Per-port request stages around one shared storage array
 */

`timescale 1ns/100ps
`default_nettype none

`include "test_mem_config.svh"

module test_mem_multiport (
  input  logic                   clk,
  input  logic                   reset,

  // Request ports
  input  logic                   memreq_val_i  [`TM_NUM_PORTS],
  output logic                   memreq_rdy_o  [`TM_NUM_PORTS],
  input  mem_msg_pkg::mem_req_t  memreq_msg_i  [`TM_NUM_PORTS],

  // Response ports
  output logic                   memresp_val_o [`TM_NUM_PORTS],
  input  logic                   memresp_rdy_i [`TM_NUM_PORTS],
  output mem_msg_pkg::mem_resp_t memresp_msg_o [`TM_NUM_PORTS]
);

  // --------------------
  // Stage to array nets
  // --------------------

  mem_geom_pkg::block_addr_t rd_addr [`TM_NUM_PORTS];
  logic [`TM_DATA_W-1:0]     rd_word [`TM_NUM_PORTS];
  mem_geom_pkg::mem_write_t  wr_cmd  [`TM_NUM_PORTS];

  // --------------------
  // Port stages
  // --------------------

  // Each port stalls on its own response ready
  for (genvar p = 0; p < `TM_NUM_PORTS; p++) begin : g_port
    mem_port_stage u_stage (
      .clk           (clk),
      .reset         (reset),
      .memreq_val_i  (memreq_val_i[p]),
      .memreq_msg_i  (memreq_msg_i[p]),
      .memreq_rdy_o  (memreq_rdy_o[p]),
      .memresp_val_o (memresp_val_o[p]),
      .memresp_msg_o (memresp_msg_o[p]),
      .memresp_rdy_i (memresp_rdy_i[p]),
      .rd_addr_o     (rd_addr[p]),
      .rd_word_i     (rd_word[p]),
      .wr_cmd_o      (wr_cmd[p])
    );
  end

  // --------------------
  // Shared storage
  // --------------------

  // Ports see each other's writes from the following edge on
  mem_array u_array (
    .clk       (clk),
    .rd_addr_i (rd_addr),
    .rd_word_o (rd_word),
    .wr_cmd_i  (wr_cmd)
  );

endmodule

`default_nettype wire

// File: test/test_mem_chk.sv
/*
 * Handshake assertions for the multi-ported test memory
 * Ready follow, no X on inputs, stall hold, quiet reset
 */

`timescale 1ns/100ps
`default_nettype none

`include "test_mem_config.svh"

module test_mem_chk (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   memreq_val_i  [`TM_NUM_PORTS],
  input  logic                   memreq_rdy_o  [`TM_NUM_PORTS],
  input  logic                   memresp_val_o [`TM_NUM_PORTS],
  input  logic                   memresp_rdy_i [`TM_NUM_PORTS],
  input  mem_msg_pkg::mem_resp_t memresp_msg_o [`TM_NUM_PORTS]
);

  for (genvar p = 0; p < `TM_NUM_PORTS; p++) begin : g_chk

    // Strict stall, request ready mirrors response ready
    a_rdy_follow: assert property (@(posedge clk)
      memreq_rdy_o[p] == memresp_rdy_i[p])
      else $error("port %0d request ready differs from response ready", p);

    // Handshake inputs are driven once reset is over
    a_no_x: assert property (@(posedge clk) disable iff (reset)
      !$isunknown({memreq_val_i[p], memresp_rdy_i[p]}))
      else $error("port %0d request valid or response ready is unknown", p);

    // A stalled response keeps valid, op and length
    // Read data must hold too, write data follows the array
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
      (memresp_val_o[p] && !memresp_rdy_i[p]) |=>
        ($stable(memresp_val_o[p]) && $stable(memresp_msg_o[p].op) &&
         $stable(memresp_msg_o[p].len) &&
         (memresp_msg_o[p].op == mem_msg_pkg::op_write ||
          $stable(memresp_msg_o[p].data))))
      else $error("port %0d response changed while stalled", p);

    // No response comes out of a reset cycle
    a_reset_quiet: assert property (@(posedge clk)
      reset |=> !memresp_val_o[p])
      else $error("port %0d response valid high after a reset edge", p);

  end

endmodule

`default_nettype wire

// File: test/test_mem_tb.sv
/*
 * Testbench for the multi-ported test memory
 * Clock, reset, stimulus table, reference byte model,
 * compare tasks, random stall lengths and watchdog
 */

`timescale 1ns/100ps
`default_nettype none

`include "test_mem_config.svh"

module test_mem_tb;

  localparam int clk_period = 8;
  localparam int wb         = `TM_DATA_W / 8;
  localparam mem_msg_pkg::mem_op_e rd = mem_msg_pkg::op_read;
  localparam mem_msg_pkg::mem_op_e wr = mem_msg_pkg::op_write;

  // One table row
  // Grouped rows go out on the same edge
  typedef struct packed {
    logic [7:0]            port;
    mem_msg_pkg::mem_req_t req;
    logic [`TM_DATA_W-1:0] exp_data;
    logic                  stall;
    logic                  grouped;
  } stim_t;

  logic                   clk;
  logic                   reset;
  logic                   req_val  [`TM_NUM_PORTS];
  logic                   req_rdy  [`TM_NUM_PORTS];
  mem_msg_pkg::mem_req_t  req_msg  [`TM_NUM_PORTS];
  logic                   resp_val [`TM_NUM_PORTS];
  logic                   resp_rdy [`TM_NUM_PORTS];
  mem_msg_pkg::mem_resp_t resp_msg [`TM_NUM_PORTS];

  stim_t       stim_q [$];
  logic [7:0]  ref_mem [`TM_MEM_BYTES];
  logic [31:0] lfsr = 32'hab26;

  test_mem_multiport uut (
    .clk           (clk),
    .reset         (reset),
    .memreq_val_i  (req_val),
    .memreq_rdy_o  (req_rdy),
    .memreq_msg_i  (req_msg),
    .memresp_val_o (resp_val),
    .memresp_rdy_i (resp_rdy),
    .memresp_msg_o (resp_msg)
  );

  bind test_mem_multiport test_mem_chk u_chk (
    .clk           (clk),
    .reset         (reset),
    .memreq_val_i  (memreq_val_i),
    .memreq_rdy_o  (memreq_rdy_o),
    .memresp_val_o (memresp_val_o),
    .memresp_rdy_i (memresp_rdy_i),
    .memresp_msg_o (memresp_msg_o)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------
  // Reporting and compares
  // --------------------

  task automatic report_fail(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_fail($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    end
  endtask

  // Write responses carry no meaningful data
  task automatic check_resp(input string name, input mem_msg_pkg::mem_resp_t got,
                            input mem_msg_pkg::mem_resp_t exp);
    if (got.op !== exp.op) begin
      report_fail($sformatf("FAILED %s.op: got %h expected %h", name, got.op, exp.op));
    end
    if (got.len !== exp.len) begin
      report_fail($sformatf("FAILED %s.len: got %h expected %h", name, got.len, exp.len));
    end
    if (exp.op == rd && got.data !== exp.data) begin
      report_fail($sformatf("FAILED %s.data: got %h expected %h", name, got.data, exp.data));
    end
  endtask

  // --------------------
  // Reference byte model
  // --------------------

  // Bytes from the address up to the word end with zeros above
  function automatic logic [`TM_DATA_W-1:0] expected_word(input logic [`TM_ADDR_W-1:0] addr);
    int phys;
    int off;
    logic [`TM_DATA_W-1:0] w;
    phys = int'(addr) % `TM_MEM_BYTES;
    off  = phys % wb;
    w    = '0;
    for (int i = 0; i < wb; i++) begin
      if (off + i < wb) w[8*i +: 8] = ref_mem[phys + i];
    end
    return w;
  endfunction

  // Len zero is a whole word
  // Bytes past the word end are lost
  task automatic model_store(input mem_msg_pkg::mem_req_t req);
    int phys;
    int off;
    int cnt;
    phys = int'(req.addr) % `TM_MEM_BYTES;
    off  = phys % wb;
    cnt  = (req.len == '0) ? wb : int'(req.len);
    for (int i = 0; i < cnt; i++) begin
      if (off + i < wb) ref_mem[phys + i] = req.data[8*i +: 8];
    end
  endtask

  // --------------------
  // Random stall lengths
  // --------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  // --------------------
  // Table and drivers
  // --------------------

  task automatic add_entry(input int port, input mem_msg_pkg::mem_op_e op,
                           input logic [`TM_ADDR_W-1:0] addr, input logic [`TM_LEN_W-1:0] len,
                           input logic [`TM_DATA_W-1:0] data, input logic [`TM_DATA_W-1:0] exp,
                           input logic stall, input logic grouped);
    stim_t e;
    e.port     = 8'(port);
    e.req      = '{op: op, addr: addr, len: len, data: data};
    e.exp_data = exp;
    e.stall    = stall;
    e.grouped  = grouped;
    stim_q.push_back(e);
  endtask

  // Response is checked against both the table and the byte model
  task automatic check_entry(input stim_t e);
    mem_msg_pkg::mem_resp_t exp;
    string name;
    name = $sformatf("port%0d memresp_msg_o", e.port);
    check_bit($sformatf("port%0d memresp_val_o", e.port), resp_val[e.port], 1'b1);
    exp = '{op: e.req.op, len: e.req.len, data: expected_word(e.req.addr)};
    check_resp(name, resp_msg[e.port], exp);
    exp.data = e.exp_data;
    check_resp(name, resp_msg[e.port], exp);
  endtask

  // Holds response ready low for a random number of cycles
  task automatic hold_response(input stim_t e);
    int n;
    rand_bits(3, n);
    resp_rdy[e.port] = 1'b0;
    repeat (n + 1) begin
      @(posedge clk);
      #1;
      check_bit($sformatf("port%0d memreq_rdy_o", e.port), req_rdy[e.port], 1'b0);
      check_entry(e);
    end
    resp_rdy[e.port] = 1'b1;
  endtask

  // Limit grows with the table at 20 cycles per row plus reset
  initial begin
    int limit;
    #1;
    limit = (stim_q.size() * 20 + 16) * clk_period;
    #(limit);
    report_fail("watchdog expired before the stimulus table was done");
  end

  initial begin
    int i;
    int j;
    for (int p = 0; p < `TM_NUM_PORTS; p++) begin
      req_val[p]  = 1'b0;
      req_msg[p]  = '0;
      resp_rdy[p] = 1'b1;
    end
    reset = 1'b1;

    // Port, op, addr, len, data, expected read data, stall, grouped
    add_entry(0, wr, 16'h0010, 2'd0, 32'hdeadbeef, 32'h0, 1'b0, 1'b0);
    add_entry(0, rd, 16'h0010, 2'd0, 32'h0, 32'hdeadbeef, 1'b0, 1'b0);
    add_entry(1, wr, 16'h0020, 2'd0, 32'h11223344, 32'h0, 1'b0, 1'b0);
    add_entry(1, wr, 16'h0021, 2'd1, 32'h000000a5, 32'h0, 1'b0, 1'b0);
    add_entry(1, rd, 16'h0020, 2'd0, 32'h0, 32'h1122a544, 1'b0, 1'b0);
    add_entry(2, wr, 16'h0023, 2'd2, 32'h0000bbcc, 32'h0, 1'b0, 1'b0);
    add_entry(2, rd, 16'h0021, 2'd0, 32'h0, 32'h00cc22a5, 1'b0, 1'b0);
    add_entry(2, rd, 16'h0022, 2'd2, 32'h0, 32'h0000cc22, 1'b0, 1'b0);
    add_entry(0, wr, 16'h0030, 2'd0, 32'hcafef00d, 32'h0, 1'b0, 1'b0);
    add_entry(3, rd, 16'h0030, 2'd0, 32'h0, 32'hcafef00d, 1'b0, 1'b0);
    add_entry(3, rd, 16'h1130, 2'd0, 32'h0, 32'hcafef00d, 1'b0, 1'b0);
    add_entry(1, rd, 16'h0010, 2'd0, 32'h0, 32'hdeadbeef, 1'b1, 1'b0);
    add_entry(3, wr, 16'h0012, 2'd2, 32'h00007788, 32'h0, 1'b1, 1'b0);
    add_entry(2, rd, 16'h0010, 2'd0, 32'h0, 32'h7788beef, 1'b0, 1'b0);
    add_entry(0, wr, 16'h0040, 2'd0, 32'h0, 32'h0, 1'b0, 1'b0);
    add_entry(1, wr, 16'h0041, 2'd1, 32'h00000055, 32'h0, 1'b0, 1'b1);
    add_entry(2, wr, 16'h0041, 2'd1, 32'h00000066, 32'h0, 1'b0, 1'b0);
    add_entry(0, rd, 16'h0040, 2'd0, 32'h0, 32'h00006600, 1'b0, 1'b0);
    add_entry(0, rd, 16'h0013, 2'd1, 32'h0, 32'h00000077, 1'b0, 1'b1);
    add_entry(1, rd, 16'h0022, 2'd0, 32'h0, 32'h0000cc22, 1'b0, 1'b1);
    add_entry(2, rd, 16'h0033, 2'd0, 32'h0, 32'h000000ca, 1'b0, 1'b1);
    add_entry(3, rd, 16'h0041, 2'd0, 32'h0, 32'h00000066, 1'b0, 1'b0);

    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int p = 0; p < `TM_NUM_PORTS; p++) begin
      check_bit($sformatf("port%0d memresp_val_o", p), resp_val[p], 1'b0);
    end

    i = 0;
    while (i < stim_q.size()) begin
      j = i;
      while (stim_q[j].grouped && j + 1 < stim_q.size()) j++;
      for (int k = i; k <= j; k++) begin
        req_val[stim_q[k].port] = 1'b1;
        req_msg[stim_q[k].port] = stim_q[k].req;
      end
      @(posedge clk);
      #1;
      // Idle ports, including one just released from a stall, show no response
      for (int p = 0; p < `TM_NUM_PORTS; p++) begin
        if (!req_val[p]) begin
          check_bit($sformatf("port%0d memresp_val_o", p), resp_val[p], 1'b0);
        end
      end
      for (int k = i; k <= j; k++) begin
        check_entry(stim_q[k]);
        req_val[stim_q[k].port] = 1'b0;
      end
      // Table order matches port order so the higher port lands last
      for (int k = i; k <= j; k++) begin
        if (stim_q[k].req.op == wr) model_store(stim_q[k].req);
      end
      if (i == j && stim_q[i].stall) hold_response(stim_q[i]);
      i = j + 1;
    end

    // Last responses drain on the next edge
    @(posedge clk);
    #1;
    for (int p = 0; p < `TM_NUM_PORTS; p++) begin
      check_bit($sformatf("port%0d memresp_val_o", p), resp_val[p], 1'b0);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+design
design/mem_msg_pkg.sv
design/mem_geom_pkg.sv
design/mem_port_stage.sv
design/mem_array.sv
design/test_mem_multiport.sv
test/test_mem_chk.sv
test/test_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the test memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=Vtest_mem_tb

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

echo "Building simulation"
if ! verilator --binary --assert -j 0 -f verilog.f --top-module test_mem_tb \
    --Mdir "$OBJ" -o "$BIN"; then
  echo "Build failed"
  exit 1
fi

echo "Running simulation"
"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit 1
fi

if ! grep -q "Result: PASSED" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
